/* hdl/rvPkg.sv */
package rvPkg;

    // Datapath and address width
    localparam int XLEN = 32;

    // Register index width, x0 to x31
    localparam int REG_AW = 5;

    // Data memory, word addressed by address bits 9:2
    localparam int DMEM_WORDS = 256;
    localparam int DMEM_AW = $clog2(DMEM_WORDS);

    localparam logic [XLEN-1:0] RESET_PC = '0;

    // Major opcodes
    localparam logic [6:0] OP_RTYPE  = 7'b0110011;
    localparam logic [6:0] OP_ITYPE  = 7'b0010011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;

    // Funct3 codes of the supported ALU operations
    localparam logic [2:0] F3_ADD = 3'b000;
    localparam logic [2:0] F3_SLT = 3'b010;
    localparam logic [2:0] F3_OR  = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;

    // Instruction bit that turns add into sub for R-type
    localparam int F7_SUB_BIT = 30;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT
    } aluOpT;

    typedef enum logic [1:0] {
        WB_ALU,
        WB_MEM,
        WB_LINK
    } wbSelT;

endpackage

/* hdl/rvCtrlIf.sv */
`timescale 1ns/1ns

interface rvCtrlIf
    import rvPkg::*;
();

    aluOpT             aluOp;
    logic              aluSrcImm;
    logic              isBranch;
    logic              isJump;
    logic              memRead;
    logic              memWrite;
    logic              regWrite;
    wbSelT             wbSel;
    logic [XLEN-1:0]   imm;
    logic [REG_AW-1:0] rs1;
    logic [REG_AW-1:0] rs2;
    logic [REG_AW-1:0] rd;

    modport decode (
        output aluOp, aluSrcImm, isBranch, isJump,
        output memRead, memWrite, regWrite, wbSel,
        output imm, rs1, rs2, rd
    );

    modport execute (
        input aluOp, aluSrcImm, isBranch, isJump, imm
    );

    modport result (
        input memRead, memWrite, regWrite, wbSel, rd
    );

endinterface

/* hdl/rvFetch.sv */
`timescale 1ns/1ns

module rvFetch
    import rvPkg::*;
(
    input  logic            clk,
    input  logic            rstN,
    input  logic [XLEN-1:0] pcNext,
    input  logic [XLEN-1:0] entryPoint,
    input  logic            intReq,
    output logic [XLEN-1:0] pc
);

    // Interrupt wins over any branch or jump target
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc <= RESET_PC;
        end else if (intReq) begin
            pc <= entryPoint;
        end else begin
            pc <= pcNext;
        end
    end

endmodule

/* hdl/rvDecode.sv */
`timescale 1ns/1ns

module rvDecode
    import rvPkg::*;
(
    input  logic [XLEN-1:0] ins,
    rvCtrlIf.decode         ctrl
);

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [XLEN-1:0] immI;
    logic [XLEN-1:0] immS;
    logic [XLEN-1:0] immB;
    logic [XLEN-1:0] immJ;

    function automatic aluOpT aluFromFunct3(input logic [2:0] f3, input logic subSel);
        aluOpT op;
        case (f3)
            F3_ADD:  op = subSel ? ALU_SUB : ALU_ADD;
            F3_SLT:  op = ALU_SLT;
            F3_OR:   op = ALU_OR;
            F3_AND:  op = ALU_AND;
            default: op = ALU_ADD;
        endcase
        return op;
    endfunction

    assign opcode = ins[6:0];
    assign funct3 = ins[14:12];

    assign ctrl.rs1 = ins[19:15];
    assign ctrl.rs2 = ins[24:20];
    assign ctrl.rd  = ins[11:7];

    // Sign-extended immediates, B and J carry their zero low bit
    assign immI = {{(XLEN-12){ins[31]}}, ins[31:20]};
    assign immS = {{(XLEN-12){ins[31]}}, ins[31:25], ins[11:7]};
    assign immB = {{(XLEN-13){ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
    assign immJ = {{(XLEN-21){ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};

    always_comb begin
        // Unknown opcodes fall through as a harmless pc plus 4
        ctrl.aluOp     = ALU_ADD;
        ctrl.aluSrcImm = 1'b0;
        ctrl.isBranch  = 1'b0;
        ctrl.isJump    = 1'b0;
        ctrl.memRead   = 1'b0;
        ctrl.memWrite  = 1'b0;
        ctrl.regWrite  = 1'b0;
        ctrl.wbSel     = WB_ALU;
        ctrl.imm       = '0;
        case (opcode)
            OP_RTYPE: begin
                ctrl.aluOp    = aluFromFunct3(funct3, ins[F7_SUB_BIT]);
                ctrl.regWrite = 1'b1;
            end
            OP_ITYPE: begin
                ctrl.aluOp     = aluFromFunct3(funct3, 1'b0);
                ctrl.aluSrcImm = 1'b1;
                ctrl.regWrite  = 1'b1;
                ctrl.imm       = immI;
            end
            OP_LOAD: begin
                ctrl.aluSrcImm = 1'b1;
                ctrl.memRead   = 1'b1;
                ctrl.regWrite  = 1'b1;
                ctrl.wbSel     = WB_MEM;
                ctrl.imm       = immI;
            end
            OP_STORE: begin
                ctrl.aluSrcImm = 1'b1;
                ctrl.memWrite  = 1'b1;
                ctrl.imm       = immS;
            end
            OP_BRANCH: begin
                // Compare by subtraction, the zero flag decides
                ctrl.aluOp    = ALU_SUB;
                ctrl.isBranch = 1'b1;
                ctrl.imm      = immB;
            end
            OP_JAL: begin
                ctrl.isJump   = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.wbSel    = WB_LINK;
                ctrl.imm      = immJ;
            end
            default: begin
            end
        endcase
    end

endmodule

/* hdl/rvRegFile.sv */
`timescale 1ns/1ns

module rvRegFile
    import rvPkg::*;
(
    input  logic              clk,
    input  logic              rstN,
    input  logic [REG_AW-1:0] rs1,
    input  logic [REG_AW-1:0] rs2,
    input  logic [REG_AW-1:0] rd,
    input  logic [XLEN-1:0]   wd,
    input  logic              we,
    output logic [XLEN-1:0]   rs1Data,
    output logic [XLEN-1:0]   rs2Data
);

    // x0 has no storage
    logic [XLEN-1:0] regs [1:31];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != '0) begin
            regs[rd] <= wd;
        end
    end

    assign rs1Data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2Data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

/* hdl/rvExecute.sv */
`timescale 1ns/1ns

module rvExecute
    import rvPkg::*;
(
    rvCtrlIf.execute        ctrl,
    input  logic [XLEN-1:0] pc,
    input  logic [XLEN-1:0] rs1Data,
    input  logic [XLEN-1:0] rs2Data,
    output logic [XLEN-1:0] aluResult,
    output logic [XLEN-1:0] pcPlus4,
    output logic [XLEN-1:0] pcNext
);

    logic [XLEN-1:0] opB;
    logic [XLEN-1:0] pcTarget;
    logic            zero;
    logic            takeBranch;

    assign opB = ctrl.aluSrcImm ? ctrl.imm : rs2Data;

    always_comb begin
        case (ctrl.aluOp)
            ALU_ADD: aluResult = rs1Data + opB;
            ALU_SUB: aluResult = rs1Data - opB;
            ALU_AND: aluResult = rs1Data & opB;
            ALU_OR:  aluResult = rs1Data | opB;
            // Signed compare, result in bit 0
            ALU_SLT: aluResult = {{(XLEN-1){1'b0}}, $signed(rs1Data) < $signed(opB)};
            default: aluResult = rs1Data + opB;
        endcase
    end

    assign zero = (aluResult == '0);

    assign takeBranch = ctrl.isBranch && zero;

    // Same adder serves beq and jal targets
    assign pcTarget = pc + ctrl.imm;
    assign pcPlus4  = pc + XLEN'(4);

    assign pcNext = (ctrl.isJump || takeBranch) ? pcTarget : pcPlus4;

endmodule

/* hdl/rvResult.sv */
`timescale 1ns/1ns

module rvResult
    import rvPkg::*;
(
    input  logic              clk,
    rvCtrlIf.result           ctrl,
    input  logic [XLEN-1:0]   aluResult,
    input  logic [XLEN-1:0]   rs2Data,
    input  logic [XLEN-1:0]   pcPlus4,
    output logic [XLEN-1:0]   wbData,
    output logic              wbEn,
    output logic [REG_AW-1:0] wbRd
);

    logic [XLEN-1:0]    dmem [DMEM_WORDS];
    logic [DMEM_AW-1:0] wordIdx;
    logic [XLEN-1:0]    loadData;

    // Byte offset bits are ignored
    assign wordIdx = aluResult[DMEM_AW+1:2];

    always_ff @(posedge clk) begin
        if (ctrl.memWrite) begin
            dmem[wordIdx] <= rs2Data;
        end
    end

    assign loadData = ctrl.memRead ? dmem[wordIdx] : '0;

    always_comb begin
        case (ctrl.wbSel)
            WB_ALU:  wbData = aluResult;
            WB_MEM:  wbData = loadData;
            WB_LINK: wbData = pcPlus4;
            default: wbData = aluResult;
        endcase
    end

    // Writes to x0 are dropped here
    assign wbEn = ctrl.regWrite && (ctrl.rd != '0);
    assign wbRd = ctrl.rd;

endmodule

/* hdl/rvCore.sv */
`timescale 1ns/1ns

module rvCore
    import rvPkg::*;
(
    input  logic              clk,
    input  logic              rstN,
    input  logic [XLEN-1:0]   ins,
    input  logic [XLEN-1:0]   entryPoint,
    input  logic              intReq,
    output logic [XLEN-1:0]   pc,
    output logic [XLEN-1:0]   wbData,
    output logic              wbEn,
    output logic [REG_AW-1:0] wbRd
);

    logic [XLEN-1:0] rs1Data;
    logic [XLEN-1:0] rs2Data;
    logic [XLEN-1:0] aluResult;
    logic [XLEN-1:0] pcNext;
    logic [XLEN-1:0] pcPlus4;

    rvCtrlIf ctrl ();

    rvFetch i_rvFetch (
        .clk        (clk),
        .rstN       (rstN),
        .pcNext     (pcNext),
        .entryPoint (entryPoint),
        .intReq     (intReq),
        .pc         (pc)
    );

    rvDecode i_rvDecode (
        .ins  (ins),
        .ctrl (ctrl)
    );

    // Write port is fed back from the writeback stage
    rvRegFile i_rvRegFile (
        .clk     (clk),
        .rstN    (rstN),
        .rs1     (ctrl.rs1),
        .rs2     (ctrl.rs2),
        .rd      (wbRd),
        .wd      (wbData),
        .we      (wbEn),
        .rs1Data (rs1Data),
        .rs2Data (rs2Data)
    );

    rvExecute i_rvExecute (
        .ctrl      (ctrl),
        .pc        (pc),
        .rs1Data   (rs1Data),
        .rs2Data   (rs2Data),
        .aluResult (aluResult),
        .pcPlus4   (pcPlus4),
        .pcNext    (pcNext)
    );

    rvResult i_rvResult (
        .clk       (clk),
        .ctrl      (ctrl),
        .aluResult (aluResult),
        .rs2Data   (rs2Data),
        .pcPlus4   (pcPlus4),
        .wbData    (wbData),
        .wbEn      (wbEn),
        .wbRd      (wbRd)
    );

endmodule

/* sim/tbCore.sv */
`timescale 1ns/1ns

module tbCore
    import rvPkg::*;
();

    localparam int CLK_PERIOD   = 100;
    localparam int SAMPLE_DELAY = 25;
    localparam int RESET_CYCLES = 5;
    localparam int IMEM_WORDS   = 1024;
    localparam int RUN_LIMIT    = 64;

    localparam logic [15:0] LFSR_SEED = 16'd25510;
    localparam logic [15:0] LFSR_TAPS = 16'hB400;

    localparam logic [6:0] F7_ZERO = 7'b0000000;
    localparam logic [6:0] F7_SUB  = 7'b0100000;
    localparam logic [2:0] F3_WORD = 3'b010;

    logic            clk;
    logic            rstN;
    logic [XLEN-1:0] ins;
    logic [XLEN-1:0] entryPoint;
    logic            intReq;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] wbData;
    logic            wbEn;
    logic [4:0]      wbRd;

    // Instruction image indexed by pc bits 11:2
    logic [XLEN-1:0] imem [IMEM_WORDS];
    logic [XLEN-1:0] prog [$];

    // Reference model state
    logic [XLEN-1:0] modelRegs [32];
    logic [XLEN-1:0] modelMem [DMEM_WORDS];
    logic [XLEN-1:0] modelPc;

    logic [15:0] lfsrState;
    string       testName;

    rvCore i_rvCore (
        .clk        (clk),
        .rstN       (rstN),
        .ins        (ins),
        .entryPoint (entryPoint),
        .intReq     (intReq),
        .pc         (pc),
        .wbData     (wbData),
        .wbEn       (wbEn),
        .wbRd       (wbRd)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    // Galois LFSR stepped once per bit
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            val = {val[30:0], lfsrState[0]};
            lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ LFSR_TAPS) : (lfsrState >> 1);
        end
        return val;
    endfunction

    function automatic logic [31:0] rTypeWord(input logic [6:0] f7, input logic [4:0] rs2,
                                              input logic [4:0] rs1, input logic [2:0] f3,
                                              input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OP_RTYPE};
    endfunction

    function automatic logic [31:0] iTypeWord(input logic [6:0] op, input logic [11:0] imm,
                                              input logic [4:0] rs1, input logic [2:0] f3,
                                              input logic [4:0] rd);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] sTypeWord(input logic [11:0] imm, input logic [4:0] rs2,
                                              input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, F3_WORD, imm[4:0], OP_STORE};
    endfunction

    function automatic logic [31:0] bTypeWord(input logic [12:0] off, input logic [4:0] rs2,
                                              input logic [4:0] rs1);
        return {off[12], off[10:5], rs2, rs1, 3'b000, off[4:1], off[11], OP_BRANCH};
    endfunction

    function automatic logic [31:0] jTypeWord(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, OP_JAL};
    endfunction

    function automatic logic [31:0] aluRef(input logic [2:0] f3, input logic subSel,
                                           input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'b000:  return subSel ? a - b : a + b;
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b110:  return a | b;
            3'b111:  return a & b;
            default: return a + b;
        endcase
    endfunction

    task automatic abortRun();
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic checkValue(input string what, input logic [31:0] expected,
                              input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("FAILED %s %s: expected %h, actual %h", testName, what, expected, actual);
            abortRun();
        end
    endtask

    // Executes one instruction on the model state
    task automatic modelStep(input logic [31:0] w, output logic expEn, output logic [4:0] expRd,
                             output logic [31:0] expData, output logic [31:0] expNext);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] immI;
        logic [31:0] immS;
        logic [31:0] immB;
        logic [31:0] immJ;
        logic [31:0] addr;
        logic        doWrite;
        a       = modelRegs[w[19:15]];
        b       = modelRegs[w[24:20]];
        immI    = {{20{w[31]}}, w[31:20]};
        immS    = {{20{w[31]}}, w[31:25], w[11:7]};
        immB    = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        immJ    = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
        doWrite = 1'b0;
        expData = '0;
        expNext = modelPc + 32'd4;
        case (w[6:0])
            OP_RTYPE: begin
                doWrite = 1'b1;
                expData = aluRef(w[14:12], w[30], a, b);
            end
            OP_ITYPE: begin
                doWrite = 1'b1;
                expData = aluRef(w[14:12], 1'b0, a, immI);
            end
            OP_LOAD: begin
                doWrite = 1'b1;
                addr    = a + immI;
                expData = modelMem[addr[9:2]];
            end
            OP_STORE: begin
                addr = a + immS;
                modelMem[addr[9:2]] = b;
            end
            OP_BRANCH: begin
                if (a == b) begin
                    expNext = modelPc + immB;
                end
            end
            OP_JAL: begin
                doWrite = 1'b1;
                expData = modelPc + 32'd4;
                expNext = modelPc + immJ;
            end
            default: begin
            end
        endcase
        expRd = w[11:7];
        expEn = doWrite && (expRd != 5'd0);
        if (expEn) begin
            modelRegs[expRd] = expData;
        end
    endtask

    // Runs from one falling edge to the next
    task automatic stepCycle(input logic irq, input logic [31:0] entry);
        logic [31:0] word;
        logic        expEn;
        logic [4:0]  expRd;
        logic [31:0] expData;
        logic [31:0] expNext;
        checkValue("pc", modelPc, pc);
        word       = imem[modelPc[11:2]];
        ins        = word;
        intReq     = irq;
        entryPoint = entry;
        #(SAMPLE_DELAY);
        modelStep(word, expEn, expRd, expData, expNext);
        checkValue("wbEn", {31'b0, expEn}, {31'b0, wbEn});
        if (expEn) begin
            checkValue("wbRd", {27'b0, expRd}, {27'b0, wbRd});
            checkValue("wbData", expData, wbData);
        end
        modelPc = irq ? entry : expNext;
        @(negedge clk);
    endtask

    task automatic loadProgram(input logic [31:0] base, output logic [31:0] endPc);
        logic [9:0] idx;
        for (int i = 0; i < prog.size(); i++) begin
            idx = base[11:2] + 10'(i);
            imem[idx] = prog[i];
        end
        endPc = base + (32'(prog.size()) << 2);
        prog.delete();
    endtask

    task automatic runProgram(input logic [31:0] endPc);
        int cycles;
        cycles = 0;
        while (modelPc != endPc) begin
            if (cycles >= RUN_LIMIT) begin
                $display("Timeout: test %s did not reach pc %h within %0d cycles",
                         testName, endPc, RUN_LIMIT);
                abortRun();
            end
            stepCycle(1'b0, 32'd0);
            cycles++;
        end
        // Next pc of the last instruction
        checkValue("pc", modelPc, pc);
    endtask

    task automatic resetTest();
        logic [31:0] endPc;
        testName = "reset";
        // Opcode 1111111 with a nonzero rd field
        prog.push_back(32'h0000_2a7f);
        prog.push_back(rTypeWord(F7_ZERO, 5'd7, 5'd6, F3_ADD, 5'd5));
        loadProgram(modelPc, endPc);
        checkValue("pc after reset", RESET_PC, pc);
        runProgram(endPc);
    endtask

    task automatic arithTest();
        logic [31:0] endPc;
        logic [11:0] immX;
        logic [11:0] immY;
        logic [11:0] immZ;
        testName = "arith";
        for (int k = 0; k < 4; k++) begin
            immX = 12'(randBits(12));
            immY = 12'(randBits(12));
            immZ = 12'(randBits(12));
            prog.push_back(iTypeWord(OP_ITYPE, immX, 5'd0, F3_ADD, 5'd1));
            prog.push_back(iTypeWord(OP_ITYPE, immY, 5'd0, F3_ADD, 5'd2));
            prog.push_back(rTypeWord(F7_ZERO, 5'd2, 5'd1, F3_ADD, 5'd3));
            prog.push_back(rTypeWord(F7_SUB, 5'd2, 5'd1, F3_ADD, 5'd4));
            prog.push_back(rTypeWord(F7_ZERO, 5'd2, 5'd1, F3_AND, 5'd5));
            prog.push_back(rTypeWord(F7_ZERO, 5'd2, 5'd1, F3_OR, 5'd6));
            prog.push_back(rTypeWord(F7_ZERO, 5'd2, 5'd1, F3_SLT, 5'd7));
            prog.push_back(rTypeWord(F7_ZERO, 5'd1, 5'd2, F3_SLT, 5'd8));
            prog.push_back(iTypeWord(OP_ITYPE, immZ, 5'd1, F3_AND, 5'd9));
            prog.push_back(iTypeWord(OP_ITYPE, immZ, 5'd2, F3_OR, 5'd10));
            prog.push_back(iTypeWord(OP_ITYPE, immZ, 5'd1, F3_SLT, 5'd11));
            // Writes to x0 must not show up
            prog.push_back(iTypeWord(OP_ITYPE, immZ, 5'd1, F3_ADD, 5'd0));
            prog.push_back(rTypeWord(F7_ZERO, 5'd2, 5'd1, F3_ADD, 5'd0));
            prog.push_back(rTypeWord(F7_ZERO, 5'd1, 5'd0, F3_ADD, 5'd12));
            loadProgram(modelPc, endPc);
            runProgram(endPc);
        end
    endtask

    task automatic memoryTest();
        logic [31:0] endPc;
        logic [11:0] base;
        logic [11:0] offs [4];
        testName = "memory";
        base = 12'(randBits(6)) << 2;
        prog.push_back(iTypeWord(OP_ITYPE, base, 5'd0, F3_ADD, 5'd13));
        for (int k = 0; k < 4; k++) begin
            offs[k] = 12'(k * 16) + (12'(randBits(2)) << 2);
            prog.push_back(iTypeWord(OP_ITYPE, 12'(randBits(12)), 5'd0, F3_ADD, 5'(14 + k)));
            prog.push_back(sTypeWord(offs[k], 5'(14 + k), 5'd13));
        end
        for (int k = 0; k < 4; k++) begin
            prog.push_back(iTypeWord(OP_LOAD, offs[k], 5'd13, F3_WORD, 5'(18 + k)));
        end
        loadProgram(modelPc, endPc);
        runProgram(endPc);
    endtask

    task automatic controlTest();
        logic [31:0] endPc;
        logic [11:0] immV;
        testName = "control";
        // Odd value never equal to x0
        immV = 12'(randBits(12)) | 12'd1;
        prog.push_back(iTypeWord(OP_ITYPE, immV, 5'd0, F3_ADD, 5'd20));
        prog.push_back(iTypeWord(OP_ITYPE, immV, 5'd0, F3_ADD, 5'd21));
        prog.push_back(bTypeWord(13'd8, 5'd21, 5'd20));
        prog.push_back(iTypeWord(OP_ITYPE, 12'd1, 5'd0, F3_ADD, 5'd22));
        prog.push_back(bTypeWord(13'd8, 5'd0, 5'd20));
        prog.push_back(iTypeWord(OP_ITYPE, 12'd5, 5'd0, F3_ADD, 5'd23));
        prog.push_back(jTypeWord(21'd8, 5'd24));
        prog.push_back(iTypeWord(OP_ITYPE, 12'd7, 5'd0, F3_ADD, 5'd25));
        loadProgram(modelPc, endPc);
        runProgram(endPc);
    endtask

    task automatic interruptTest();
        logic [31:0] endPc;
        logic [31:0] entry;
        testName = "interrupt";
        // Upper half of the image clear of the earlier programs
        entry = 32'h800 + (32'(randBits(8)) << 2);
        prog.push_back(iTypeWord(OP_ITYPE, 12'(randBits(12)), 5'd0, F3_ADD, 5'd26));
        prog.push_back(bTypeWord(13'd8, 5'd0, 5'd0));
        prog.push_back(iTypeWord(OP_ITYPE, 12'd1, 5'd0, F3_ADD, 5'd29));
        loadProgram(modelPc, endPc);
        prog.push_back(iTypeWord(OP_ITYPE, 12'd3, 5'd26, F3_ADD, 5'd27));
        prog.push_back(rTypeWord(F7_ZERO, 5'd26, 5'd27, F3_ADD, 5'd28));
        loadProgram(entry, endPc);
        stepCycle(1'b0, 32'd0);
        // Interrupt must win over the taken beq
        stepCycle(1'b1, entry);
        checkValue("pc at entry point", entry, pc);
        runProgram(endPc);
    endtask

    initial begin
        rstN       = 1'b0;
        ins        = 32'h0000_007f;
        entryPoint = '0;
        intReq     = 1'b0;
        lfsrState  = LFSR_SEED;
        // Unknown opcode tagged with its own word index
        for (int i = 0; i < IMEM_WORDS; i++) begin
            imem[i] = {15'd0, 10'(i), 7'h7f};
        end
        for (int i = 0; i < 32; i++) begin
            modelRegs[i] = '0;
        end
        modelPc = RESET_PC;
        for (int i = 0; i < RESET_CYCLES; i++) begin
            @(posedge clk);
        end
        @(negedge clk);
        rstN = 1'b1;
        resetTest();
        arithTest();
        memoryTest();
        controlTest();
        interruptTest();
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

/* tb.f */
hdl/rvPkg.sv
hdl/rvCtrlIf.sv
hdl/rvFetch.sv
hdl/rvDecode.sv
hdl/rvRegFile.sv
hdl/rvExecute.sv
hdl/rvResult.sv
hdl/rvCore.sv
sim/tbCore.sv

/* Makefile */
.PHONY: run clean

run:
	verilator --binary --timing --assert -j 0 --top-module tbCore -Mdir obj_dir -f tb.f
	./obj_dir/VtbCore | tee /dev/stderr | grep -q "^Simulation finished: PASS$$"

clean:
	rm -rf obj_dir
